//--- Makefile
# Verilator build for the decode and issue stage
VERILATOR ?= verilator
TOP       ?= decode_issue_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal
PASS_STR  ?= ** PASS **

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_STR)'

clean:
	rm -rf $(BUILD_DIR)

//--- dv/decode_issue_checker.sv
`timescale 1ns/1ns

module decode_issue_checker (
    input logic clk,
    input logic rst,
    input logic iq_read_i,
    input logic alu_valid_i,
    input logic cmp_valid_i,
    input logic lsb_valid_i
);

    logic any_valid;

    assign any_valid = alu_valid_i || cmp_valid_i || lsb_valid_i;

    // entries are cleared by the reset edge
    valid_low_after_reset: assert property (@(posedge clk) rst |=> !any_valid)
        else $error("entry valid high in the cycle after reset");

    one_entry_at_a_time: assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_valid_i, cmp_valid_i, lsb_valid_i}))
        else $error("more than one entry valid");

    // every issue comes from a pop one cycle earlier
    valid_needs_pop: assert property (@(posedge clk) disable iff (rst)
        any_valid |-> $past(iq_read_i))
        else $error("entry valid without a pop in the previous cycle");

endmodule

//--- dv/decode_issue_tb.sv
`timescale 1ns/1ns

module decode_issue_tb;

    logic                               clk;
    logic                               rst;
    logic                               iq_valid;
    logic [31:0]                        iq_instr;
    logic [31:0]                        iq_pc;
    logic                               iq_read;
    logic [4:0]                         rf_rs1;
    logic [4:0]                         rf_rs2;
    rv_decode_pkg::regfile_out_t        rf_entry;
    rv_decode_pkg::rob_arr_t            rob_entries;
    logic [2:0]                         free_tag;
    logic                               rob_full;
    logic                               rob_write;
    rv_decode_pkg::rob_alloc_t          rob_alloc;
    logic                               rat_write;
    logic [4:0]                         rat_rd;
    logic [2:0]                         rat_tag;
    logic                               alu_full;
    logic                               cmp_full;
    logic                               lsb_full;
    rv_decode_pkg::alu_entry_t          alu;
    rv_decode_pkg::cmp_entry_t          cmp;
    rv_decode_pkg::lsb_entry_t          lsb;

    // register file and reorder buffer models
    logic [31:0] rf_val [32];
    logic [2:0]  rf_tag [32];
    logic        rob_rdy [8];
    logic [31:0] rob_val [8];
    int unsigned cycles;
    int unsigned cycle_limit;
    int          waited;

    decode_issue i_dut (
        .clk            (clk),
        .rst            (rst),
        .iq_valid_i     (iq_valid),
        .iq_instr_i     (iq_instr),
        .iq_pc_i        (iq_pc),
        .iq_read_o      (iq_read),
        .rf_rs1_o       (rf_rs1),
        .rf_rs2_o       (rf_rs2),
        .rf_entry_i     (rf_entry),
        .rob_entries_i  (rob_entries),
        .rob_free_tag_i (free_tag),
        .rob_full_i     (rob_full),
        .rob_write_o    (rob_write),
        .rob_alloc_o    (rob_alloc),
        .rat_write_o    (rat_write),
        .rat_rd_o       (rat_rd),
        .rat_tag_o      (rat_tag),
        .alu_full_i     (alu_full),
        .alu_o          (alu),
        .cmp_full_i     (cmp_full),
        .cmp_o          (cmp),
        .lsb_full_i     (lsb_full),
        .lsb_o          (lsb)
    );

    bind decode_issue decode_issue_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .iq_read_i   (iq_read_o),
        .alu_valid_i (alu_o.valid),
        .cmp_valid_i (cmp_o.valid),
        .lsb_valid_i (lsb_o.valid)
    );

    assign rf_entry = '{vj: rf_val[rf_rs1], qj: rf_tag[rf_rs1],
                        vk: rf_val[rf_rs2], qk: rf_tag[rf_rs2]};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            rob_entries[i] = '{ready: rob_rdy[i], value: rob_val[i]};
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    task automatic check_alu(input rv_decode_pkg::alu_entry_t exp);
        if (alu !== exp) report_error($sformatf("alu entry %h, expected %h", alu, exp));
    endtask

    task automatic check_cmp(input rv_decode_pkg::cmp_entry_t exp);
        if (cmp !== exp) report_error($sformatf("cmp entry %h, expected %h", cmp, exp));
    endtask

    task automatic check_lsb(input rv_decode_pkg::lsb_entry_t exp);
        if (lsb !== exp) report_error($sformatf("lsb entry %h, expected %h", lsb, exp));
    endtask

    task automatic check_alloc(input rv_decode_pkg::rob_alloc_t exp);
        if (rob_alloc !== exp) report_error($sformatf("rob alloc %h, expected %h", rob_alloc, exp));
    endtask

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r_format(input logic sub, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv_decode_pkg::operand_t known(input logic [31:0] value);
        return '{value: value, tag: 3'd0, ready: 1'b1};
    endfunction

    // completed producers forward their value and pending ones pass the tag on
    function automatic rv_decode_pkg::operand_t operand_for(input logic [4:0] idx);
        logic [2:0] t;
        t = rf_tag[idx];
        if (t != 3'd0 && rob_rdy[t]) return known(rob_val[t]);
        return '{value: rf_val[idx], tag: t, ready: (t == 3'd0)};
    endfunction

    task automatic no_entry_valid();
        check_bit("alu valid", alu.valid, 1'b0);
        check_bit("cmp valid", cmp.valid, 1'b0);
        check_bit("lsb valid", lsb.valid, 1'b0);
    endtask

    // the waiting instruction must not pop, rename or issue
    task automatic hold_three_cycles();
        repeat (3) begin
            #70;
            check_bit("iq_read_o while stalled", iq_read, 1'b0);
            check_bit("rat_write_o while stalled", rat_write, 1'b0);
            @(posedge clk);
            #10;
            check_bit("rob_write_o while stalled", rob_write, 1'b0);
            no_entry_valid();
        end
    endtask

    // drive, wait for the pop, then check the registered result edge
    task automatic pop_instr(input logic [31:0] instr, input logic [31:0] pc,
                             input logic exp_issue, input logic exp_rename,
                             input logic [4:0] rd, output int stall);
        iq_instr = instr;
        iq_pc    = pc;
        iq_valid = 1'b1;
        stall    = 0;
        #70;
        while (!iq_read) begin
            @(posedge clk);
            #80;
            stall++;
        end
        check_bit("rat_write_o", rat_write, exp_rename);
        if (exp_rename) begin
            check_bit("rat_rd_o", rat_rd, rd);
            check_bit("rat_tag_o", rat_tag, free_tag);
        end
        @(posedge clk);
        #10;
        iq_valid = 1'b0;
        check_bit("rob_write_o", rob_write, exp_issue);
        if (!exp_issue) no_entry_valid();
    endtask

    task automatic issue_alu(input logic [31:0] instr, input logic [31:0] pc,
                             input rv_decode_pkg::opcode_e opc, input logic [4:0] rd,
                             input rv_decode_pkg::alu_entry_t exp);
        pop_instr(instr, pc, 1'b1, 1'b1, rd, waited);
        check_alu(exp);
        check_bit("cmp valid", cmp.valid, 1'b0);
        check_bit("lsb valid", lsb.valid, 1'b0);
        check_alloc('{pc: pc, opcode: opc, rd: rd});
    endtask

    task automatic reset_then_alu();
        repeat (2) begin
            @(posedge clk);
            #10;
            check_bit("iq_read_o in reset", iq_read, 1'b0);
            check_bit("rat_write_o in reset", rat_write, 1'b0);
            check_bit("rob_write_o in reset", rob_write, 1'b0);
            no_entry_valid();
        end
        rst = 1'b0;
        // addi x5, x1, -5 was waiting through reset
        issue_alu(iq_instr, 32'h100, rv_decode_pkg::op_imm, 5'd5,
                  '{1'b1, operand_for(1), known(32'hffff_fffb),
                    rv_decode_pkg::alu_add, free_tag});
        check_bit("cycles waited after reset", waited, 0);
        issue_alu(r_format(1'b0, 5'd2, 5'd1, 3'b000, 5'd6), 32'h104, rv_decode_pkg::op_reg, 5'd6,
                  '{1'b1, operand_for(1), operand_for(2), rv_decode_pkg::alu_add, free_tag});
        issue_alu(r_format(1'b1, 5'd4, 5'd3, 3'b000, 5'd7), 32'h108, rv_decode_pkg::op_reg, 5'd7,
                  '{1'b1, operand_for(3), operand_for(4), rv_decode_pkg::alu_sub, free_tag});
        issue_alu(r_format(1'b0, 5'd1, 5'd2, 3'b001, 5'd8), 32'h10c, rv_decode_pkg::op_reg, 5'd8,
                  '{1'b1, operand_for(2), operand_for(1), rv_decode_pkg::alu_sll, free_tag});
        issue_alu(i_format(12'h0ff, 5'd3, 3'b100, 5'd9, 7'b0010011), 32'h110,
                  rv_decode_pkg::op_imm, 5'd9,
                  '{1'b1, operand_for(3), known(32'h0ff), rv_decode_pkg::alu_xor, free_tag});
        issue_alu({20'h12345, 5'd10, 7'b0010111}, 32'h114, rv_decode_pkg::op_auipc, 5'd10,
                  '{1'b1, known(32'h114), known(32'h1234_5000),
                    rv_decode_pkg::alu_add, free_tag});
    endtask

    task automatic bypass_operands();
        rf_tag[2]  = 3'd4;
        rob_rdy[4] = 1'b1;
        rob_val[4] = $urandom;
        rf_tag[3]  = 3'd6;
        rob_rdy[6] = 1'b0;
        free_tag   = 3'd2;
        issue_alu(r_format(1'b0, 5'd3, 5'd2, 3'b110, 5'd11), 32'h200, rv_decode_pkg::op_reg,
                  5'd11,
                  '{1'b1, known(rob_val[4]), '{rf_val[3], 3'd6, 1'b0},
                    rv_decode_pkg::alu_or, 3'd2});
        rf_tag[2] = 3'd0;
        rf_tag[3] = 3'd0;
    endtask

    task automatic branch_and_memory();
        pop_instr(b_format(13'h1ff0, 5'd2, 5'd1, 3'b100), 32'h300, 1'b1, 1'b0, 5'd0, waited);
        check_cmp('{1'b1, operand_for(1), operand_for(2), 32'h300, 32'hffff_fff0,
                    rv_decode_pkg::br_blt, free_tag});
        check_alloc('{pc: 32'h300, opcode: rv_decode_pkg::op_br, rd: 5'd0});
        pop_instr(i_format(12'd12, 5'd1, 3'b010, 5'd9, 7'b0000011), 32'h304, 1'b1, 1'b1, 5'd9,
                  waited);
        check_lsb('{1'b1, 1'b0, operand_for(1), known(32'd0), 32'd12,
                    rv_decode_pkg::mem_w, free_tag});
        check_alloc('{pc: 32'h304, opcode: rv_decode_pkg::op_load, rd: 5'd9});
        // rd bits of a store hold a nonzero imm[4:0] here
        pop_instr(s_format(12'hff8, 5'd2, 5'd1, 3'b001), 32'h308, 1'b1, 1'b0, 5'd0, waited);
        check_lsb('{1'b1, 1'b1, operand_for(1), operand_for(2), 32'hffff_fff8,
                    rv_decode_pkg::mem_h, free_tag});
        check_alloc('{pc: 32'h308, opcode: rv_decode_pkg::op_store, rd: 5'd0});
    endtask

    task automatic stall_and_release(input int kind);
        case (kind)
            0:       alu_full = 1'b1;
            1:       rob_full = 1'b1;
            default: free_tag = 3'd0;
        endcase
        iq_instr = i_format(12'h07f, 5'd1, 3'b111, 5'd12, 7'b0010011);
        iq_pc    = 32'h400;
        iq_valid = 1'b1;
        hold_three_cycles();
        alu_full = 1'b0;
        rob_full = 1'b0;
        free_tag = 3'd5;
        issue_alu(iq_instr, 32'h400, rv_decode_pkg::op_imm, 5'd12,
                  '{1'b1, operand_for(1), known(32'h07f), rv_decode_pkg::alu_and, 3'd5});
        check_bit("cycles waited after release", waited, 0);
        @(posedge clk);
        #10;
        check_bit("second rob_write_o", rob_write, 1'b0);
        no_entry_valid();
    endtask

    // a full station holds only the instructions bound for it
    task automatic full_station_holds();
        cmp_full = 1'b1;
        iq_instr = b_format(13'h0008, 5'd4, 5'd3, 3'b001);
        iq_pc    = 32'h600;
        iq_valid = 1'b1;
        hold_three_cycles();
        cmp_full = 1'b0;
        alu_full = 1'b1;
        lsb_full = 1'b1;
        pop_instr(iq_instr, 32'h600, 1'b1, 1'b0, 5'd0, waited);
        check_bit("cycles waited for cmp", waited, 0);
        check_cmp('{1'b1, operand_for(3), operand_for(4), 32'h600, 32'h8,
                    rv_decode_pkg::br_bne, free_tag});
        // lbu x13, 32(x2) waits on the load-store station
        iq_instr = i_format(12'h020, 5'd2, 3'b100, 5'd13, 7'b0000011);
        iq_pc    = 32'h604;
        iq_valid = 1'b1;
        hold_three_cycles();
        lsb_full = 1'b0;
        cmp_full = 1'b1;
        pop_instr(iq_instr, 32'h604, 1'b1, 1'b1, 5'd13, waited);
        check_bit("cycles waited for lsb", waited, 0);
        check_lsb('{1'b1, 1'b0, operand_for(2), known(32'd0), 32'h20,
                    rv_decode_pkg::mem_bu, free_tag});
        alu_full = 1'b0;
        cmp_full = 1'b0;
    endtask

    task automatic discard_without_issue();
        pop_instr(i_format(12'd1, 5'd1, 3'b000, 5'd0, 7'b0010011), 32'h500, 1'b0, 1'b0, 5'd0,
                  waited);
        pop_instr({20'habcde, 5'd5, 7'b0110111}, 32'h504, 1'b0, 1'b0, 5'd0, waited);
    endtask

    initial begin
        int seed_val;
        seed_val    = $urandom(32'hc6a70d9d);
        cycles      = 0;
        cycle_limit = 400;
        rst         = 1'b1;
        iq_valid    = 1'b1;
        iq_instr    = i_format(12'hffb, 5'd1, 3'b000, 5'd5, 7'b0010011);
        iq_pc       = 32'h100;
        free_tag    = 3'd3;
        rob_full    = 1'b0;
        alu_full    = 1'b0;
        cmp_full    = 1'b0;
        lsb_full    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rf_val[i] = (i == 0) ? 32'd0 : $urandom;
            rf_tag[i] = 3'd0;
        end
        for (int i = 0; i < 8; i++) begin
            rob_rdy[i] = 1'b0;
            rob_val[i] = $urandom;
        end
        reset_then_alu();
        bypass_operands();
        branch_and_memory();
        for (int k = 0; k < 3; k++) begin
            stall_and_release(k);
        end
        full_station_holds();
        discard_without_issue();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- hdl/decode_issue.sv
`timescale 1ns/1ns

module decode_issue (
    input  logic                                 clk,
    input  logic                                 rst,

    // instruction queue
    input  logic                                 iq_valid_i,
    input  logic [rv_decode_pkg::XLEN-1:0]       iq_instr_i,
    input  logic [rv_decode_pkg::XLEN-1:0]       iq_pc_i,
    output logic                                 iq_read_o,

    // register file
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rf_rs1_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rf_rs2_o,
    input  rv_decode_pkg::regfile_out_t          rf_entry_i,

    // reorder buffer
    input  rv_decode_pkg::rob_arr_t              rob_entries_i,
    input  logic [rv_decode_pkg::ROB_TAG_W-1:0]  rob_free_tag_i,
    input  logic                                 rob_full_i,
    output logic                                 rob_write_o,
    output rv_decode_pkg::rob_alloc_t            rob_alloc_o,

    // rename table
    output logic                                 rat_write_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rat_rd_o,
    output logic [rv_decode_pkg::ROB_TAG_W-1:0]  rat_tag_o,

    // stations
    input  logic                                 alu_full_i,
    output rv_decode_pkg::alu_entry_t            alu_o,
    input  logic                                 cmp_full_i,
    output rv_decode_pkg::cmp_entry_t            cmp_o,
    input  logic                                 lsb_full_i,
    output rv_decode_pkg::lsb_entry_t            lsb_o
);

    rv_decode_pkg::opcode_e               opcode;
    logic [2:0]                           funct3;
    logic                                 funct7_bit;
    logic [rv_decode_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_decode_pkg::XLEN-1:0]       imm_i;
    logic [rv_decode_pkg::XLEN-1:0]       imm_s;
    logic [rv_decode_pkg::XLEN-1:0]       imm_b;
    logic [rv_decode_pkg::XLEN-1:0]       imm_u;
    rv_decode_pkg::unit_e                 unit;
    logic                                 writes_rd;
    rv_decode_pkg::operand_t              src1;
    rv_decode_pkg::operand_t              src2;
    logic                                 issue;

    instr_fields i_fields (
        .instr_i      (iq_instr_i),
        .opcode_o     (opcode),
        .funct3_o     (funct3),
        .funct7_bit_o (funct7_bit),
        .rs1_o        (rf_rs1_o),
        .rs2_o        (rf_rs2_o),
        .rd_o         (rd),
        .imm_i_o      (imm_i),
        .imm_s_o      (imm_s),
        .imm_b_o      (imm_b),
        .imm_u_o      (imm_u),
        .unit_o       (unit),
        .writes_rd_o  (writes_rd)
    );

    operand_resolve i_resolve (
        .rf_entry_i    (rf_entry_i),
        .rob_entries_i (rob_entries_i),
        .src1_o        (src1),
        .src2_o        (src2)
    );

    issue_control i_control (
        .rst            (rst),
        .iq_valid_i     (iq_valid_i),
        .unit_i         (unit),
        .rd_i           (rd),
        .writes_rd_i    (writes_rd),
        .rob_full_i     (rob_full_i),
        .rob_free_tag_i (rob_free_tag_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .lsb_full_i     (lsb_full_i),
        .iq_read_o      (iq_read_o),
        .issue_o        (issue),
        .rat_write_o    (rat_write_o),
        .rat_rd_o       (rat_rd_o),
        .rat_tag_o      (rat_tag_o)
    );

    issue_regs i_regs (
        .clk            (clk),
        .rst            (rst),
        .issue_i        (issue),
        .unit_i         (unit),
        .opcode_i       (opcode),
        .funct3_i       (funct3),
        .funct7_bit_i   (funct7_bit),
        .pc_i           (iq_pc_i),
        .rd_i           (rd),
        .imm_i_i        (imm_i),
        .imm_s_i        (imm_s),
        .imm_b_i        (imm_b),
        .imm_u_i        (imm_u),
        .src1_i         (src1),
        .src2_i         (src2),
        .rob_free_tag_i (rob_free_tag_i),
        .rob_write_o    (rob_write_o),
        .rob_alloc_o    (rob_alloc_o),
        .alu_o          (alu_o),
        .cmp_o          (cmp_o),
        .lsb_o          (lsb_o)
    );

endmodule

//--- hdl/instr_fields.sv
`timescale 1ns/1ns

module instr_fields (
    input  logic [rv_decode_pkg::XLEN-1:0]       instr_i,
    output rv_decode_pkg::opcode_e               opcode_o,
    output logic [2:0]                           funct3_o,
    output logic                                 funct7_bit_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [rv_decode_pkg::XLEN-1:0]       imm_i_o,
    output logic [rv_decode_pkg::XLEN-1:0]       imm_s_o,
    output logic [rv_decode_pkg::XLEN-1:0]       imm_b_o,
    output logic [rv_decode_pkg::XLEN-1:0]       imm_u_o,
    output rv_decode_pkg::unit_e                 unit_o,
    output logic                                 writes_rd_o
);

    logic arith_kept;

    assign opcode_o     = rv_decode_pkg::opcode_e'(instr_i[6:0]);
    assign funct3_o     = instr_i[14:12];
    assign funct7_bit_o = instr_i[30];
    assign rs1_o        = instr_i[19:15];
    assign rs2_o        = instr_i[24:20];
    assign rd_o         = instr_i[11:7];

    // sign-extended immediates
    assign imm_i_o = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                      instr_i[11:8], 1'b0};
    assign imm_u_o = {instr_i[31:12], 12'h000};

    // add, sll, xor, or, and only; slt and the right shifts are not handled
    always_comb begin
        case (funct3_o)
            3'b000, 3'b001, 3'b100, 3'b110, 3'b111: arith_kept = 1'b1;
            default:                                arith_kept = 1'b0;
        endcase
    end

    always_comb begin
        unit_o      = rv_decode_pkg::unit_none;
        writes_rd_o = 1'b0;
        case (opcode_o)
            rv_decode_pkg::op_auipc: begin
                unit_o      = rv_decode_pkg::unit_alu;
                writes_rd_o = 1'b1;
            end
            rv_decode_pkg::op_imm: begin
                writes_rd_o = 1'b1;
                if (arith_kept) unit_o = rv_decode_pkg::unit_alu;
            end
            rv_decode_pkg::op_reg: begin
                writes_rd_o = 1'b1;
                // funct7 bit 5 is only legal on add (sub)
                if (arith_kept && (!funct7_bit_o || funct3_o == 3'b000)) begin
                    unit_o = rv_decode_pkg::unit_alu;
                end
            end
            rv_decode_pkg::op_br: unit_o = rv_decode_pkg::unit_cmp;
            rv_decode_pkg::op_load: begin
                unit_o      = rv_decode_pkg::unit_lsb;
                writes_rd_o = 1'b1;
            end
            rv_decode_pkg::op_store: unit_o = rv_decode_pkg::unit_lsb;
            default: ;
        endcase
    end

endmodule

//--- hdl/issue_control.sv
`timescale 1ns/1ns

module issue_control (
    input  logic                                  rst,
    input  logic                                  iq_valid_i,
    input  rv_decode_pkg::unit_e                  unit_i,
    input  logic [rv_decode_pkg::REG_ADDR_W-1:0]  rd_i,
    input  logic                                  writes_rd_i,
    input  logic                                  rob_full_i,
    input  logic [rv_decode_pkg::ROB_TAG_W-1:0]   rob_free_tag_i,
    input  logic                                  alu_full_i,
    input  logic                                  cmp_full_i,
    input  logic                                  lsb_full_i,
    output logic                                  iq_read_o,
    output logic                                  issue_o,
    output logic                                  rat_write_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0]  rat_rd_o,
    output logic [rv_decode_pkg::ROB_TAG_W-1:0]   rat_tag_o
);

    logic target_full;
    logic resources_ok;
    logic discard;

    // full flag of the selected station
    always_comb begin
        case (unit_i)
            rv_decode_pkg::unit_alu: target_full = alu_full_i;
            rv_decode_pkg::unit_cmp: target_full = cmp_full_i;
            rv_decode_pkg::unit_lsb: target_full = lsb_full_i;
            default:                 target_full = 1'b1;
        endcase
    end

    // stores and branches carry no rd, so rd zero only matters for writers
    assign discard = iq_valid_i &&
                     (unit_i == rv_decode_pkg::unit_none || (writes_rd_i && rd_i == '0));

    assign resources_ok = !rob_full_i && rob_free_tag_i != '0 && !target_full;

    // no pop while the stage is held in reset
    assign issue_o   = !rst && iq_valid_i && !discard && resources_ok;
    assign iq_read_o = issue_o || (!rst && discard);

    // rename rd to the tag being allocated
    assign rat_write_o = issue_o && writes_rd_i;
    assign rat_rd_o    = rd_i;
    assign rat_tag_o   = rob_free_tag_i;

endmodule

//--- hdl/issue_regs.sv
`timescale 1ns/1ns

module issue_regs (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_i,
    input  rv_decode_pkg::unit_e                 unit_i,
    input  rv_decode_pkg::opcode_e               opcode_i,
    input  logic [2:0]                           funct3_i,
    input  logic                                 funct7_bit_i,
    input  logic [rv_decode_pkg::XLEN-1:0]       pc_i,
    input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rv_decode_pkg::XLEN-1:0]       imm_i_i,
    input  logic [rv_decode_pkg::XLEN-1:0]       imm_s_i,
    input  logic [rv_decode_pkg::XLEN-1:0]       imm_b_i,
    input  logic [rv_decode_pkg::XLEN-1:0]       imm_u_i,
    input  rv_decode_pkg::operand_t              src1_i,
    input  rv_decode_pkg::operand_t              src2_i,
    input  logic [rv_decode_pkg::ROB_TAG_W-1:0]  rob_free_tag_i,
    output logic                                 rob_write_o,
    output rv_decode_pkg::rob_alloc_t            rob_alloc_o,
    output rv_decode_pkg::alu_entry_t            alu_o,
    output rv_decode_pkg::cmp_entry_t            cmp_o,
    output rv_decode_pkg::lsb_entry_t            lsb_o
);

    rv_decode_pkg::alu_entry_t alu_d;
    rv_decode_pkg::cmp_entry_t cmp_d;
    rv_decode_pkg::lsb_entry_t lsb_d;
    rv_decode_pkg::rob_alloc_t alloc_d;
    logic                      is_store;

    // operand known at decode, nothing to wait for
    function automatic rv_decode_pkg::operand_t known_operand(
        input logic [rv_decode_pkg::XLEN-1:0] value
    );
        rv_decode_pkg::operand_t opnd;
        opnd.value = value;
        opnd.tag   = '0;
        opnd.ready = 1'b1;
        return opnd;
    endfunction

    assign is_store = (opcode_i == rv_decode_pkg::op_store);

    // alu entry
    always_comb begin
        alu_d.valid   = issue_i && unit_i == rv_decode_pkg::unit_alu;
        alu_d.rs1     = src1_i;
        alu_d.rs2     = src2_i;
        alu_d.op      = rv_decode_pkg::alu_op_e'({1'b0, funct3_i});
        alu_d.rob_idx = rob_free_tag_i;
        case (opcode_i)
            rv_decode_pkg::op_auipc: begin
                // pc + upper immediate
                alu_d.rs1 = known_operand(pc_i);
                alu_d.rs2 = known_operand(imm_u_i);
                alu_d.op  = rv_decode_pkg::alu_add;
            end
            rv_decode_pkg::op_imm: alu_d.rs2 = known_operand(imm_i_i);
            default: begin
                if (funct3_i == 3'b000 && funct7_bit_i) alu_d.op = rv_decode_pkg::alu_sub;
            end
        endcase
    end

    // compare entry, target is resolved downstream from pc and b_imm
    always_comb begin
        cmp_d.valid   = issue_i && unit_i == rv_decode_pkg::unit_cmp;
        cmp_d.rs1     = src1_i;
        cmp_d.rs2     = src2_i;
        cmp_d.pc      = pc_i;
        cmp_d.b_imm   = imm_b_i;
        cmp_d.op      = rv_decode_pkg::branch_op_e'(funct3_i);
        cmp_d.rob_idx = rob_free_tag_i;
    end

    // load-store entry
    always_comb begin
        lsb_d.valid    = issue_i && unit_i == rv_decode_pkg::unit_lsb;
        lsb_d.is_store = is_store;
        lsb_d.rs1      = src1_i;
        lsb_d.rs2      = is_store ? src2_i : known_operand('0);
        lsb_d.imm      = is_store ? imm_s_i : imm_i_i;
        lsb_d.op       = rv_decode_pkg::mem_op_e'(funct3_i);
        lsb_d.rob_idx  = rob_free_tag_i;
    end

    // no destination for stores and branches
    always_comb begin
        alloc_d.pc     = pc_i;
        alloc_d.opcode = opcode_i;
        alloc_d.rd     = (is_store || unit_i == rv_decode_pkg::unit_cmp) ? '0 : rd_i;
    end

    always_ff @(posedge clk) begin
        alu_o       <= alu_d;
        cmp_o       <= cmp_d;
        lsb_o       <= lsb_d;
        rob_alloc_o <= alloc_d;
        rob_write_o <= issue_i;
        if (rst) begin
            alu_o.valid <= 1'b0;
            cmp_o.valid <= 1'b0;
            lsb_o.valid <= 1'b0;
            rob_write_o <= 1'b0;
        end
    end

endmodule

//--- hdl/operand_resolve.sv
`timescale 1ns/1ns

module operand_resolve (
    input  rv_decode_pkg::regfile_out_t rf_entry_i,
    input  rv_decode_pkg::rob_arr_t     rob_entries_i,
    output rv_decode_pkg::operand_t     src1_o,
    output rv_decode_pkg::operand_t     src2_o
);

    // pick the rob value when the producer has already completed
    function automatic rv_decode_pkg::operand_t resolve(
        input logic [rv_decode_pkg::XLEN-1:0]      rf_value,
        input logic [rv_decode_pkg::ROB_TAG_W-1:0] rf_tag,
        input rv_decode_pkg::rob_arr_t             rob
    );
        rv_decode_pkg::operand_t opnd;
        if (rf_tag != '0 && rob[rf_tag].ready) begin
            opnd.value = rob[rf_tag].value;
            opnd.tag   = '0;
            opnd.ready = 1'b1;
        end else begin
            opnd.value = rf_value;
            opnd.tag   = rf_tag;
            opnd.ready = (rf_tag == '0);
        end
        return opnd;
    endfunction

    assign src1_o = resolve(rf_entry_i.vj, rf_entry_i.qj, rob_entries_i);
    assign src2_o = resolve(rf_entry_i.vk, rf_entry_i.qk, rob_entries_i);

endmodule

//--- hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    // datapath and index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROB_TAG_W  = 3;

    // tag 0 is reserved, it means the value is already present
    localparam int ROB_DEPTH  = 8;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // low three bits follow funct3, sub gets its own code
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000
    } alu_op_e;

    // branch conditions, as funct3
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_op_e;

    // access width and sign, as funct3
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_op_e;

    // where a decoded instruction is sent
    typedef enum logic [1:0] {
        unit_none = 2'd0,
        unit_alu  = 2'd1,
        unit_cmp  = 2'd2,
        unit_lsb  = 2'd3
    } unit_e;

    // source operand: value valid only when ready is set
    typedef struct packed {
        logic [XLEN-1:0]      value;
        logic [ROB_TAG_W-1:0] tag;
        logic                 ready;
    } operand_t;

    // register file read port, q fields are pending tags
    typedef struct packed {
        logic [XLEN-1:0]      vj;
        logic [ROB_TAG_W-1:0] qj;
        logic [XLEN-1:0]      vk;
        logic [ROB_TAG_W-1:0] qk;
    } regfile_out_t;

    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] value;
    } rob_entry_t;

    typedef rob_entry_t [ROB_DEPTH-1:0] rob_arr_t;

    // reorder buffer allocation payload
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
    } rob_alloc_t;

    typedef struct packed {
        logic                 valid;
        operand_t             rs1;
        operand_t             rs2;
        alu_op_e              op;
        logic [ROB_TAG_W-1:0] rob_idx;
    } alu_entry_t;

    typedef struct packed {
        logic                 valid;
        operand_t             rs1;
        operand_t             rs2;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      b_imm;
        branch_op_e           op;
        logic [ROB_TAG_W-1:0] rob_idx;
    } cmp_entry_t;

    // rs1 is the base, rs2 the store data
    typedef struct packed {
        logic                 valid;
        logic                 is_store;
        operand_t             rs1;
        operand_t             rs2;
        logic [XLEN-1:0]      imm;
        mem_op_e              op;
        logic [ROB_TAG_W-1:0] rob_idx;
    } lsb_entry_t;

endpackage

//--- list.f
hdl/rv_decode_pkg.sv
hdl/instr_fields.sv
hdl/operand_resolve.sv
hdl/issue_control.sv
hdl/issue_regs.sv
hdl/decode_issue.sv
dv/decode_issue_checker.sv
dv/decode_issue_tb.sv
